// File: alu.sv
`timescale 1ns/1ps

module alu (
    input  wire common::alu_mode_t alu_mode_i,   // operation select
    input  wire common::word_t     alu_op1_i,    // operand 1
    input  wire common::word_t     alu_op2_i,    // operand 2
    output      common::word_t     alu_result_o  // result
);
    import common::*;

    logic [4:0] shamt;  // shift amount from operand 2

    always_comb begin
        shamt = alu_op2_i[4:0];
        case (alu_mode_i)
            ALU_ADD:   alu_result_o = alu_op1_i + alu_op2_i;
            ALU_SUB:   alu_result_o = alu_op1_i - alu_op2_i;
            ALU_AND:   alu_result_o = alu_op1_i & alu_op2_i;
            ALU_OR:    alu_result_o = alu_op1_i | alu_op2_i;
            ALU_XOR:   alu_result_o = alu_op1_i ^ alu_op2_i;
            ALU_SLL:   alu_result_o = alu_op1_i << shamt;
            ALU_SRL:   alu_result_o = alu_op1_i >> shamt;
            ALU_SRA:   alu_result_o = word_t'($signed(alu_op1_i) >>> shamt);
            ALU_SLT: begin
                alu_result_o = word_t'($signed(alu_op1_i) < $signed(alu_op2_i));
            end
            ALU_SLTU:  alu_result_o = word_t'(alu_op1_i < alu_op2_i);
            ALU_PASS2: alu_result_o = alu_op2_i;
            default:   alu_result_o = '0;  // unused encodings
        endcase
    end

endmodule

// File: common.sv
package common;

    typedef logic [31:0] word_t;     // data and address word
    typedef logic [4:0]  regaddr_t;  // destination register index
    typedef logic [1:0]  lane_t;     // byte lane inside a word
    typedef logic [3:0]  byte_en_t;  // one write enable per byte

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLL   = 4'd5,
        ALU_SRL   = 4'd6,
        ALU_SRA   = 4'd7,
        ALU_SLT   = 4'd8,
        ALU_SLTU  = 4'd9,
        ALU_PASS2 = 4'd10  // operand 2 straight through, for lui
    } alu_mode_t;

    typedef enum logic [1:0] {
        MA_NONE  = 2'd0,
        MA_LOAD  = 2'd1,
        MA_STORE = 2'd2
    } ma_mode_t;

    typedef enum logic [2:0] {
        MA_BYTE   = 3'd0,
        MA_HALF   = 3'd1,
        MA_WORD   = 3'd2,
        MA_BYTE_U = 3'd3,
        MA_HALF_U = 3'd4
    } ma_size_t;

    typedef enum logic [1:0] {
        WB_SRC_ALU  = 2'd0,
        WB_SRC_MEM  = 2'd1,
        WB_SRC_PASS = 2'd2  // supplied data, e.g. a link address
    } wb_src_t;

    // idle slot
    localparam word_t    NOP_PC       = '1;
    localparam word_t    NOP_IR       = 32'h0000_0013;  // addi x0, x0, 0
    localparam ma_mode_t NOP_MA_MODE  = MA_NONE;
    localparam ma_size_t NOP_MA_SIZE  = MA_WORD;
    localparam wb_src_t  NOP_WB_SRC   = WB_SRC_PASS;
    localparam logic     NOP_WB_VALID = 1'b0;

    // word index width of the data memory, at least one bit
    function automatic int dmem_addr_w(int words);
        int w;
        w = (words > 1) ? $clog2(words) : 1;
        return w;
    endfunction

endpackage

// File: cpu_backend.sv
`timescale 1ns/1ps

module cpu_backend #(
    parameter int DMEM_WORDS = 256  // data memory depth in words
) (
    input  wire logic              clk_i,
    input  wire logic              reset_i,

    input  wire common::word_t     pc_i,
    input  wire common::word_t     ir_i,
    input  wire common::word_t     alu_op1_i,
    input  wire common::word_t     alu_op2_i,
    input  wire common::alu_mode_t alu_mode_i,
    input  wire common::ma_mode_t  ma_mode_i,
    input  wire common::ma_size_t  ma_size_i,
    input  wire common::word_t     ma_data_i,
    input  wire common::wb_src_t   wb_src_i,
    input  wire common::word_t     wb_data_i,
    input  wire logic              wb_valid_i,

    output      common::regaddr_t  wb_addr_async_o,
    output      common::word_t     wb_data_async_o,
    output      logic              wb_ready_async_o,
    output      logic              wb_valid_async_o,
    output      logic              empty_async_o,

    output      common::word_t     pc_o,
    output      common::regaddr_t  wb_addr_o,
    output      common::word_t     wb_data_o,
    output      logic              wb_valid_o
);
    import common::*;

    localparam int ADDR_W = dmem_addr_w(DMEM_WORDS);

    // EX/MA pipeline register outputs
    word_t     ex_pc;
    word_t     ex_ir;
    word_t     ex_ma_addr;
    ma_mode_t  ex_ma_mode;
    ma_size_t  ex_ma_size;
    word_t     ex_ma_data;
    wb_src_t   ex_wb_src;
    word_t     ex_wb_data;
    logic      ex_wb_valid;

    logic [ADDR_W-1:0] mem_addr;
    byte_en_t  mem_we;
    word_t     mem_wdata;
    word_t     mem_rdata;

    cpu_ex u_ex (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .pc_i             (pc_i),
        .ir_i             (ir_i),
        .alu_op1_i        (alu_op1_i),
        .alu_op2_i        (alu_op2_i),
        .alu_mode_i       (alu_mode_i),
        .ma_mode_i        (ma_mode_i),
        .ma_size_i        (ma_size_i),
        .ma_data_i        (ma_data_i),
        .wb_src_i         (wb_src_i),
        .wb_data_i        (wb_data_i),
        .wb_valid_i       (wb_valid_i),
        .wb_addr_async_o  (wb_addr_async_o),
        .wb_data_async_o  (wb_data_async_o),
        .wb_ready_async_o (wb_ready_async_o),
        .wb_valid_async_o (wb_valid_async_o),
        .empty_async_o    (empty_async_o),
        .pc_o             (ex_pc),
        .ir_o             (ex_ir),
        .ma_addr_o        (ex_ma_addr),
        .ma_mode_o        (ex_ma_mode),
        .ma_size_o        (ex_ma_size),
        .ma_data_o        (ex_ma_data),
        .wb_src_o         (ex_wb_src),
        .wb_data_o        (ex_wb_data),
        .wb_valid_o       (ex_wb_valid)
    );

    cpu_ma #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_ma (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .ex_pc_i       (ex_pc),
        .ex_ir_i       (ex_ir),
        .ex_ma_addr_i  (ex_ma_addr),
        .ex_ma_mode_i  (ex_ma_mode),
        .ex_ma_size_i  (ex_ma_size),
        .ex_ma_data_i  (ex_ma_data),
        .ex_wb_src_i   (ex_wb_src),
        .ex_wb_data_i  (ex_wb_data),
        .ex_wb_valid_i (ex_wb_valid),
        .mem_addr_o    (mem_addr),
        .mem_we_o      (mem_we),
        .mem_wdata_o   (mem_wdata),
        .mem_rdata_i   (mem_rdata),
        .pc_o          (pc_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .wb_valid_o    (wb_valid_o)
    );

    data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk_i   (clk_i),
        .addr_i  (mem_addr),
        .we_i    (mem_we),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

// File: cpu_ex.sv
`timescale 1ns/1ps

module cpu_ex (
    input  wire logic              clk_i,
    input  wire logic              reset_i,

    input  wire common::word_t     pc_i,              // program counter
    input  wire common::word_t     ir_i,              // instruction word
    input  wire common::word_t     alu_op1_i,
    input  wire common::word_t     alu_op2_i,
    input  wire common::alu_mode_t alu_mode_i,
    input  wire common::ma_mode_t  ma_mode_i,         // none, load or store
    input  wire common::ma_size_t  ma_size_i,
    input  wire common::word_t     ma_data_i,         // store data
    input  wire common::wb_src_t   wb_src_i,
    input  wire common::word_t     wb_data_i,
    input  wire logic              wb_valid_i,

    output      common::regaddr_t  wb_addr_async_o,   // forwarding to hazard unit
    output      common::word_t     wb_data_async_o,
    output      logic              wb_ready_async_o,  // data known in this stage
    output      logic              wb_valid_async_o,
    output      logic              empty_async_o,     // slot is a bubble

    output      common::word_t     pc_o,
    output      common::word_t     ir_o,
    output      common::word_t     ma_addr_o,         // alu result as address
    output      common::ma_mode_t  ma_mode_o,
    output      common::ma_size_t  ma_size_o,
    output      common::word_t     ma_data_o,
    output      common::wb_src_t   wb_src_o,
    output      common::word_t     wb_data_o,
    output      logic              wb_valid_o
);
    import common::*;

    word_t alu_result;

    alu u_alu (
        .alu_mode_i   (alu_mode_i),
        .alu_op1_i    (alu_op1_i),
        .alu_op2_i    (alu_op2_i),
        .alu_result_o (alu_result)
    );

    always_comb begin
        wb_addr_async_o  = ir_i[11:7];  // rd field
        wb_data_async_o  = (wb_src_i == WB_SRC_ALU) ? alu_result : wb_data_i;
        wb_ready_async_o = (wb_src_i != WB_SRC_MEM);  // loads resolve in MA
        wb_valid_async_o = wb_valid_i;
        empty_async_o    = (pc_i == NOP_PC);
    end

    always_ff @(posedge clk_i) begin
        pc_o       <= pc_i;
        ir_o       <= ir_i;
        ma_addr_o  <= alu_result;
        ma_mode_o  <= ma_mode_i;
        ma_size_o  <= ma_size_i;
        ma_data_o  <= ma_data_i;
        wb_src_o   <= wb_src_i;
        wb_data_o  <= wb_data_async_o;  // alu result already merged in
        wb_valid_o <= wb_valid_i;
        if (reset_i) begin
            pc_o       <= NOP_PC;
            ir_o       <= NOP_IR;
            ma_addr_o  <= '0;
            ma_mode_o  <= NOP_MA_MODE;
            ma_size_o  <= NOP_MA_SIZE;
            ma_data_o  <= '0;
            wb_src_o   <= NOP_WB_SRC;
            wb_data_o  <= '0;
            wb_valid_o <= NOP_WB_VALID;
        end
    end

    // a store has no register result
    a_store_no_wb: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (ma_mode_i == MA_STORE) |-> !wb_valid_i
    ) else $error("cpu_ex: store slot with write-back valid");

endmodule

// File: cpu_ma.sv
`timescale 1ns/1ps

module cpu_ma #(
    parameter  int DMEM_WORDS = 256,
    localparam int ADDR_W     = common::dmem_addr_w(DMEM_WORDS)
) (
    input  wire logic             clk_i,
    input  wire logic             reset_i,

    input  wire common::word_t    ex_pc_i,
    input  wire common::word_t    ex_ir_i,
    input  wire common::word_t    ex_ma_addr_i,  // byte address
    input  wire common::ma_mode_t ex_ma_mode_i,
    input  wire common::ma_size_t ex_ma_size_i,
    input  wire common::word_t    ex_ma_data_i,
    input  wire common::wb_src_t  ex_wb_src_i,
    input  wire common::word_t    ex_wb_data_i,
    input  wire logic             ex_wb_valid_i,

    output      logic [ADDR_W-1:0] mem_addr_o,   // word index
    output      common::byte_en_t mem_we_o,
    output      common::word_t    mem_wdata_o,
    input  wire common::word_t    mem_rdata_i,   // one edge after the address

    output      common::word_t    pc_o,
    output      common::regaddr_t wb_addr_o,
    output      common::word_t    wb_data_o,
    output      logic             wb_valid_o
);
    import common::*;

    lane_t    ex_lane;
    byte_en_t st_be;
    word_t    st_data;

    // capture register, lines the slot up with the memory read data
    word_t    cap_pc;
    regaddr_t cap_rd;
    wb_src_t  cap_src;
    ma_size_t cap_size;
    lane_t    cap_lane;
    word_t    cap_data;
    logic     cap_valid;

    word_t    byte_sh;   // read word with the selected byte at the bottom
    word_t    half_sh;
    word_t    load_ext;

    assign ex_lane    = ex_ma_addr_i[1:0];
    assign mem_addr_o = ex_ma_addr_i[ADDR_W+1:2];

    always_comb begin
        case (ex_ma_size_i)
            MA_BYTE, MA_BYTE_U: begin
                st_be   = 4'b0001 << ex_lane;
                st_data = {24'b0, ex_ma_data_i[7:0]} << {ex_lane, 3'b000};
            end
            MA_HALF, MA_HALF_U: begin
                st_be   = 4'b0011 << {ex_lane[1], 1'b0};  // lane bit 0 ignored
                st_data = {16'b0, ex_ma_data_i[15:0]} << {ex_lane[1], 4'b0000};
            end
            default: begin
                st_be   = 4'b1111;
                st_data = ex_ma_data_i;
            end
        endcase
    end

    assign mem_we_o    = (ex_ma_mode_i == MA_STORE) ? st_be : 4'b0000;
    assign mem_wdata_o = st_data;

    always_ff @(posedge clk_i) begin
        cap_pc    <= ex_pc_i;
        cap_rd    <= ex_ir_i[11:7];
        cap_src   <= ex_wb_src_i;
        cap_size  <= ex_ma_size_i;
        cap_lane  <= ex_lane;
        cap_data  <= ex_wb_data_i;
        cap_valid <= ex_wb_valid_i;
        if (reset_i) begin
            cap_pc    <= NOP_PC;
            cap_src   <= NOP_WB_SRC;
            cap_size  <= NOP_MA_SIZE;
            cap_valid <= NOP_WB_VALID;
        end
    end

    always_comb begin
        byte_sh = mem_rdata_i >> {cap_lane, 3'b000};
        half_sh = mem_rdata_i >> {cap_lane[1], 4'b0000};
        case (cap_size)
            MA_BYTE:   load_ext = {{24{byte_sh[7]}}, byte_sh[7:0]};
            MA_BYTE_U: load_ext = {24'b0, byte_sh[7:0]};
            MA_HALF:   load_ext = {{16{half_sh[15]}}, half_sh[15:0]};
            MA_HALF_U: load_ext = {16'b0, half_sh[15:0]};
            default:   load_ext = mem_rdata_i;  // whole word
        endcase
    end

    always_ff @(posedge clk_i) begin
        pc_o       <= cap_pc;
        wb_addr_o  <= cap_rd;
        wb_data_o  <= (cap_src == WB_SRC_MEM) ? load_ext : cap_data;
        wb_valid_o <= cap_valid;
        if (reset_i) begin
            pc_o       <= NOP_PC;
            wb_valid_o <= NOP_WB_VALID;
        end
    end

    // word stores have no lane to steer into
    a_word_store_aligned: assert property (
        @(posedge clk_i) disable iff (reset_i)
        (ex_ma_mode_i == MA_STORE && ex_ma_size_i == MA_WORD)
            |-> (ex_ma_addr_i[1:0] == 2'b00)
    ) else $error("cpu_ma: misaligned word store");

endmodule

// File: data_mem.sv
`timescale 1ns/1ps

module data_mem #(
    parameter  int DMEM_WORDS = 256,
    localparam int ADDR_W     = common::dmem_addr_w(DMEM_WORDS)
) (
    input  wire logic             clk_i,
    input  wire logic [ADDR_W-1:0] addr_i,   // word index
    input  wire common::byte_en_t we_i,      // byte write enables
    input  wire common::word_t    wdata_i,
    output      common::word_t    rdata_o    // registered read
);
    import common::*;

    word_t mem [DMEM_WORDS];

    always_ff @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (we_i[b]) begin
                mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
        rdata_o <= mem[addr_i];  // read-before-write on the same edge
    end

    // the enables come from cpu_ma, the address from the EX result
    a_addr_known: assert property (
        @(posedge clk_i) (|we_i) |-> !$isunknown(addr_i)
    ) else $error("data_mem: write with unknown address");

endmodule

// File: project.f
common.sv
alu.sv
cpu_ex.sv
data_mem.sv
cpu_ma.sv
cpu_backend.sv
tb_cpu_backend.sv

// File: run.sh
#!/bin/sh
# build and run the backend testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_cpu_backend -f project.f -o sim_tb &&
./obj_dir/sim_tb ||
exit 1

// File: tb_cpu_backend.sv
`timescale 1ns/1ps

module tb_cpu_backend;
    import common::*;

    typedef struct packed {
        word_t    pc;
        logic     valid;
        regaddr_t rd;
        word_t    data;
    } exp_t;

    logic      clk_i;
    logic      reset_i;
    word_t     pc_i, ir_i, alu_op1_i, alu_op2_i, ma_data_i, wb_data_i;
    alu_mode_t alu_mode_i;
    ma_mode_t  ma_mode_i;
    ma_size_t  ma_size_i;
    wb_src_t   wb_src_i;
    logic      wb_valid_i;
    regaddr_t  wb_addr_async_o, wb_addr_o;
    word_t     wb_data_async_o, pc_o, wb_data_o;
    logic      wb_ready_async_o, wb_valid_async_o, empty_async_o, wb_valid_o;

    word_t      lfsr = 32'd32;
    word_t      next_pc = 32'h0000_1000;
    logic [7:0] mem_model [128];  // low 32 words only
    exp_t       exp_q [$];        // one entry per stage in flight
    word_t      exp_fwd_data;
    regaddr_t   exp_fwd_rd;
    logic       exp_fwd_valid, exp_fwd_ready;
    int         errors = 0;
    string      test_name = "reset";

    cpu_backend #(.DMEM_WORDS(256)) u_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic word_t rand_bits(int n);
        word_t r;
        logic  fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t alu_model(alu_mode_t m, word_t a, word_t b);
        logic [4:0] sh;
        word_t      fill;
        sh   = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;  // sign bits for sra
        case (m)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return (a >> sh) | fill;
            ALU_SLT:  return (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            ALU_SLTU: return {31'b0, a < b};
            default:  return b;
        endcase
    endfunction

    function automatic int size_bytes(ma_size_t s);
        case (s)
            MA_WORD:            return 4;
            MA_HALF, MA_HALF_U: return 2;
            default:            return 1;
        endcase
    endfunction

    function automatic word_t load_model(ma_size_t s, int a);
        case (s)
            MA_BYTE:   return {{24{mem_model[a][7]}}, mem_model[a]};
            MA_BYTE_U: return {24'h0, mem_model[a]};
            MA_HALF:   return {{16{mem_model[a+1][7]}}, mem_model[a+1], mem_model[a]};
            MA_HALF_U: return {16'h0, mem_model[a+1], mem_model[a]};
            default:   return {mem_model[a+3], mem_model[a+2], mem_model[a+1], mem_model[a]};
        endcase
    endfunction

    function automatic void store_model(ma_size_t s, int a, word_t d);
        for (int i = 0; i < size_bytes(s); i++) begin
            mem_model[a+i] = d[8*i +: 8];  // little endian
        end
    endfunction

    function automatic word_t fill_word(int a);
        logic [7:0] b;
        b = a[7:0];
        return {b, ~b, b ^ 8'h5a, b + 8'h33} ^ word_t'(a);
    endfunction

    function automatic exp_t nop_entry();
        exp_t e;
        e = '{pc: NOP_PC, valid: NOP_WB_VALID, rd: 5'd0, data: 32'h0};
        return e;
    endfunction

    task automatic report_mismatch(string what, word_t exp, word_t act);
        errors++;
        $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic report_stuck(string what);
        errors++;
        $display("%s: %s", test_name, what);
        $display("Verification failed");
        $fatal(1);
    endtask

    // combinational forwarding, sampled while the ex inputs are stable
    a_fwd_data: assert property (@(posedge clk_i) wb_data_async_o == exp_fwd_data)
        else report_mismatch("wb_data_async_o", exp_fwd_data, wb_data_async_o);
    a_fwd_addr: assert property (@(posedge clk_i) wb_addr_async_o == exp_fwd_rd)
        else report_mismatch("wb_addr_async_o", 32'(exp_fwd_rd), 32'(wb_addr_async_o));
    a_fwd_valid: assert property (@(posedge clk_i) wb_valid_async_o == exp_fwd_valid)
        else report_mismatch("wb_valid_async_o", 32'(exp_fwd_valid), 32'(wb_valid_async_o));
    a_fwd_ready: assert property (@(posedge clk_i) wb_ready_async_o == exp_fwd_ready)
        else report_mismatch("wb_ready_async_o", 32'(exp_fwd_ready), 32'(wb_ready_async_o));
    a_empty: assert property (@(posedge clk_i) empty_async_o == (pc_i == NOP_PC))
        else report_mismatch("empty_async_o", 32'(pc_i == NOP_PC), 32'(empty_async_o));

    task automatic check_head();
        exp_t e;
        e = exp_q.pop_front();  // slot issued three cycles ago
        assert (pc_o == e.pc) else report_mismatch("pc_o", e.pc, pc_o);
        assert (wb_valid_o == e.valid)
            else report_mismatch("wb_valid_o", 32'(e.valid), 32'(wb_valid_o));
        if (e.valid) begin
            assert (wb_addr_o == e.rd)
                else report_mismatch("wb_addr_o", 32'(e.rd), 32'(wb_addr_o));
            assert (wb_data_o == e.data) else report_mismatch("wb_data_o", e.data, wb_data_o);
        end
    endtask

    task automatic drive_slot(word_t pc, word_t ir, alu_mode_t am, word_t op1, word_t op2,
                              ma_mode_t mm, ma_size_t ms, word_t md, wb_src_t src,
                              word_t wd, logic v, word_t load_val);
        exp_t  e;
        word_t res;
        @(negedge clk_i);
        check_head();
        res        = alu_model(am, op1, op2);
        pc_i       = pc;
        ir_i       = ir;
        alu_mode_i = am;
        alu_op1_i  = op1;
        alu_op2_i  = op2;
        ma_mode_i  = mm;
        ma_size_i  = ms;
        ma_data_i  = md;
        wb_src_i   = src;
        wb_data_i  = wd;
        wb_valid_i = v;
        exp_fwd_rd    = ir[11:7];
        exp_fwd_data  = (src == WB_SRC_ALU) ? res : wd;
        exp_fwd_ready = (src != WB_SRC_MEM);  // load data only known in MA
        exp_fwd_valid = v;
        e.pc    = pc;
        e.valid = v;
        e.rd    = ir[11:7];
        case (src)
            WB_SRC_ALU: e.data = res;
            WB_SRC_MEM: e.data = load_val;
            default:    e.data = wd;
        endcase
        exp_q.push_back(e);
    endtask

    task automatic drive_nop();
        drive_slot(NOP_PC, NOP_IR, ALU_ADD, 32'h0, 32'h0, NOP_MA_MODE, NOP_MA_SIZE, 32'h0,
                   NOP_WB_SRC, 32'h0, NOP_WB_VALID, 32'h0);
    endtask

    task automatic mem_slot(logic is_store, ma_size_t ms, int a, word_t md);
        word_t    op1;
        word_t    ld;
        ma_mode_t mm;
        wb_src_t  src;
        op1 = rand_bits(32);
        ld  = 32'h0;
        if (is_store) begin
            mm  = MA_STORE;
            src = WB_SRC_PASS;  // no register result
            store_model(ms, a, md);
        end else begin
            mm  = MA_LOAD;
            src = WB_SRC_MEM;
            ld  = load_model(ms, a);
        end
        drive_slot(next_pc, rand_bits(32), ALU_ADD, op1, word_t'(a) - op1, mm, ms, md,
                   src, rand_bits(32), !is_store, ld);
        next_pc += 4;
    endtask

    function automatic bit slots_pending();
        foreach (exp_q[k]) begin
            if (exp_q[k].pc != NOP_PC) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic drain_pipeline();
        int guard;
        guard = 0;
        while (slots_pending()) begin
            if (guard == 8) begin
                report_stuck("pipeline did not drain within 8 cycles");
            end else begin
                drive_nop();
                guard++;
            end
        end
    endtask

    initial begin
        word_t     r;
        ma_size_t  ms;
        wb_src_t   src;
        int        a;
        pc_i = 32'h0000_0ff0;  // live slot held during reset
        ir_i = NOP_IR;
        alu_mode_i = ALU_ADD;
        alu_op1_i = 32'h0;
        alu_op2_i = 32'h0;
        ma_mode_i = NOP_MA_MODE;
        ma_size_i = NOP_MA_SIZE;
        ma_data_i = 32'h0;
        wb_src_i = NOP_WB_SRC;
        wb_data_i = 32'h0;
        wb_valid_i = 1'b1;
        exp_fwd_rd = NOP_IR[11:7];
        exp_fwd_data = 32'h0;
        exp_fwd_valid = 1'b1;
        exp_fwd_ready = 1'b1;
        reset_i = 1'b1;
        repeat (8) @(negedge clk_i);
        reset_i = 1'b0;
        pc_i = NOP_PC;
        wb_valid_i = NOP_WB_VALID;
        exp_fwd_valid = NOP_WB_VALID;
        for (int i = 0; i < 3; i++) begin
            exp_q.push_back(nop_entry());  // every stage holds a nop after reset
        end
        repeat (4) drive_nop();

        test_name = "alu";
        for (int i = 0; i < 220; i++) begin
            drive_slot(next_pc, rand_bits(32), alu_mode_t'(4'(i % 11)), rand_bits(32),
                       rand_bits(32), MA_NONE, MA_WORD, 32'h0, WB_SRC_ALU, rand_bits(32),
                       1'b1, 32'h0);
            next_pc += 4;
        end

        test_name = "mem_init";
        for (int w = 0; w < 32; w++) begin
            mem_slot(1'b1, MA_WORD, 4 * w, fill_word(4 * w));
        end

        test_name = "load_store";
        for (int i = 0; i < 400; i++) begin
            r  = rand_bits(1);
            ms = ma_size_t'(3'(rand_bits(3) % 5));
            a  = int'(rand_bits(7));
            a  = a & ~(size_bytes(ms) - 1);  // natural alignment
            mem_slot(r[0], ms, a, rand_bits(32));
        end

        test_name = "pass";
        for (int i = 0; i < 60; i++) begin
            r   = rand_bits(1);
            src = (r[0] == 1'b1) ? WB_SRC_PASS : WB_SRC_ALU;
            r   = rand_bits(1);
            drive_slot(next_pc, rand_bits(32), alu_mode_t'(4'(rand_bits(4) % 11)),
                       rand_bits(32), rand_bits(32), MA_NONE, MA_WORD, 32'h0, src,
                       rand_bits(32), r[0], 32'h0);
            next_pc += 4;
        end

        test_name = "drain";
        drain_pipeline();
        if (errors == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule
